// File: hdmi_tx_cfg.f
hdmi_tx_cfg_pkg.sv
adv7513_init_rom.sv
adv7513_init_seq.sv
i2c_reg_write.sv
i2c_byte_master.sv
hdmi_tx_cfg_top.sv
tb_i2c_target_model.sv
tb_hdmi_tx_cfg.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hdmi_tx_cfg
FILELIST  ?= hdmi_tx_cfg.f
OBJ_DIR   ?= obj_dir
PIXEL_REP ?= 0
SEED      ?= 52491
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR PIXEL_REP SEED VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GPIXEL_REP=$(PIXEL_REP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_hdmi_tx_cfg.sv
module tb_hdmi_tx_cfg #(
    parameter int         CLK_HZ      = 1_000_000,
    parameter int         I2C_HZ      = 50_000,
    parameter bit         PIXEL_REP   = 1'b0,
    parameter bit         ASPECT_16_9 = 1'b1,
    parameter logic [5:0] VIC_MANUAL  = 6'd6,
    parameter int         SEED        = 32'hcd0b
);
    import hdmi_tx_cfg_pkg::*;

    // one scl period in clk cycles
    localparam int BIT_CYCLES    = CLK_HZ / I2C_HZ;
    localparam int WRITE_TIMEOUT = 64 * BIT_CYCLES;
    localparam int READY_TIMEOUT = 8 * BIT_CYCLES;
    localparam int START_TIMEOUT = 8 * BIT_CYCLES;
    localparam int IDLE_CYCLES   = 400;

    // register and value pairs in table order
    localparam logic [15:0] BASE_TAB [0:INIT_LEN_BASE-1] = '{
        16'h4110, 16'h9803, 16'h9ae0, 16'h9c30, 16'h9d01, 16'ha2a4, 16'ha3a4, 16'he0d0,
        16'hf900, 16'h1500, 16'h1630, 16'h1700, 16'h1846, 16'haf06, 16'hba60, 16'h0a00,
        16'h0100, 16'h0218, 16'h0380, 16'h0b0e, 16'h0c05, 16'h0d10, 16'h94c0, 16'h96c0
    };

    logic        clk;
    logic        reset;
    logic        hdmi_int;
    logic        sda_oe;
    logic        scl_oe;
    logic        ready;
    logic        model_sda_oe;
    logic        sda_line;
    logic        scl_line;
    int          nack_at;
    int          start_count;
    int          wr_count;
    logic [7:0]  rec_addr;
    logic [7:0]  rec_reg;
    logic [7:0]  rec_value;
    logic        rec_nacked;
    logic [15:0] exp_tab [0:INIT_LEN_PR-1];
    int          exp_len;
    int          seed;

    // open drain lines with pull-ups
    assign sda_line = !(sda_oe || model_sda_oe);
    assign scl_line = !scl_oe;

    hdmi_tx_cfg_top #(
        .CLK_HZ      (CLK_HZ),
        .I2C_HZ      (I2C_HZ),
        .CHIP_ADDR   (ADV7513_ADDR),
        .PIXEL_REP   (PIXEL_REP),
        .ASPECT_16_9 (ASPECT_16_9),
        .VIC_MANUAL  (VIC_MANUAL)
    ) UUT (
        .clk      (clk),
        .reset    (reset),
        .hdmi_int (hdmi_int),
        .sda_in   (sda_line),
        .scl_in   (scl_line),
        .sda_oe   (sda_oe),
        .scl_oe   (scl_oe),
        .ready    (ready)
    );

    tb_i2c_target_model #(
        .TARGET_ADDR (7'h39)
    ) u_target (
        .clk         (clk),
        .reset       (reset),
        .scl         (scl_line),
        .sda         (sda_line),
        .nack_at     (nack_at),
        .sda_oe      (model_sda_oe),
        .start_count (start_count),
        .wr_count    (wr_count),
        .rec_addr    (rec_addr),
        .rec_reg     (rec_reg),
        .rec_value   (rec_value),
        .rec_nacked  (rec_nacked)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp_val,
                         input logic [31:0] got_val);
        if (exp_val !== got_val) begin
            fail_run($sformatf("Mismatch %s exp %h got %h", name, exp_val, got_val));
        end
    endtask

    // expected table from the register list, aspect bit and pixel repetition pair
    task automatic fill_expected();
        for (int i = 0; i < INIT_LEN_BASE; i++) begin
            exp_tab[i] = BASE_TAB[i];
        end
        // register 17 carries the 16:9 aspect bit
        if (ASPECT_16_9) begin
            exp_tab[11] = 16'h1702;
        end
        exp_tab[24] = 16'h3bc8;
        exp_tab[25] = {8'h3c, 2'b00, VIC_MANUAL};
        exp_len = PIXEL_REP ? INIT_LEN_PR : INIT_LEN_BASE;
    endtask

    task automatic wait_ready(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (ready !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                fail_run(what);
            end
        end
    endtask

    task automatic wait_record(input int target);
        int cycles;
        cycles = 0;
        while (wr_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WRITE_TIMEOUT) begin
                fail_run("timed out waiting for a register write on the bus");
            end
        end
    endtask

    // whole table in order, with entry nack_pos sent twice when it is not negative
    task automatic expect_table(input int nack_pos);
        int base;
        int n;
        int idx;
        base = wr_count;
        n = (nack_pos >= 0) ? exp_len + 1 : exp_len;
        for (int i = 0; i < n; i++) begin
            wait_record(base + i + 1);
            idx = (nack_pos >= 0 && i > nack_pos) ? i - 1 : i;
            check("rec_addr", 32'h72, 32'(rec_addr));
            check("rec_reg", 32'(exp_tab[idx][15:8]), 32'(rec_reg));
            check("rec_value", 32'(exp_tab[idx][7:0]), 32'(rec_value));
            check("rec_nacked", (i == nack_pos) ? 32'd1 : 32'd0, 32'(rec_nacked));
            check("ready", 0, 32'(ready));
        end
    endtask

    task automatic check_reset_state();
        int cycles;
        reset = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check("ready", 0, 32'(ready));
            check("scl_oe", 0, 32'(scl_oe));
        end
        reset  = 1'b1;
        cycles = 0;
        // scl stays released until the first start
        while (start_count == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > START_TIMEOUT) begin
                fail_run("no start condition appeared after reset was released");
            end
            check("ready", 0, 32'(ready));
            check("scl_oe", 0, 32'(scl_oe));
        end
    endtask

    task automatic check_full_init();
        expect_table(-1);
        wait_ready(1'b1, READY_TIMEOUT, "ready did not rise after the table was written");
        check("wr_count", 32'(exp_len), 32'(wr_count));
    endtask

    task automatic check_idle_quiet();
        int starts;
        starts = start_count;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check("ready", 1, 32'(ready));
            check("scl_oe", 0, 32'(scl_oe));
            check("sda_oe", 0, 32'(sda_oe));
        end
        check("start_count", 32'(starts), 32'(start_count));
    endtask

    // pull the interrupt low and follow the replayed table
    task automatic run_replay(input int nack_pos);
        int base;
        base = wr_count;
        @(negedge clk);
        hdmi_int = 1'b0;
        wait_ready(1'b0, 4, "ready did not fall after hdmi_int went low");
        expect_table(nack_pos);
        wait_ready(1'b1, READY_TIMEOUT, "ready did not return after the replayed table");
        hdmi_int = 1'b1;
        check("wr_count", 32'(base + exp_len + ((nack_pos >= 0) ? 1 : 0)), 32'(wr_count));
        repeat (20) begin
            @(negedge clk);
            check("ready", 1, 32'(ready));
        end
    endtask

    task automatic check_nack_retry();
        int pick;
        pick    = int'($unsigned($random(seed)) % exp_len);
        nack_at = wr_count + pick;
        $display("withholding the value acknowledge on entry %0d", pick);
        run_replay(pick);
        nack_at = -1;
    endtask

    initial begin
        reset    = 1'b0;
        hdmi_int = 1'b1;
        nack_at  = -1;
        seed     = SEED;
        fill_expected();
        check_reset_state();
        check_full_init();
        check_idle_quiet();
        run_replay(-1);
        check_nack_retry();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb_i2c_target_model.sv
module tb_i2c_target_model #(
    parameter logic [6:0] TARGET_ADDR = 7'h39
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       scl,
    input  logic       sda,
    input  int         nack_at,
    output logic       sda_oe,
    output int         start_count,
    output int         wr_count,
    output logic [7:0] rec_addr,
    output logic [7:0] rec_reg,
    output logic [7:0] rec_value,
    output logic       rec_nacked
);

    // line levels from the previous falling edge
    logic       scl_d;
    logic       sda_d;
    // between a start and a stop
    logic       busy;
    // ninth clock of a byte belongs to the acknowledge
    logic       ack_slot;
    // address byte matched this target
    logic       selected;
    // value acknowledge was withheld in this transaction
    logic       dropped;
    logic [3:0] bit_cnt;
    logic [1:0] byte_cnt;
    logic [7:0] shreg;
    logic [7:0] bytes [0:2];

    // lines move on the rising clock so look at them on the falling one
    always_ff @(negedge clk) begin
        if (!reset) begin
            scl_d       <= 1'b1;
            sda_d       <= 1'b1;
            busy        <= 1'b0;
            ack_slot    <= 1'b0;
            selected    <= 1'b0;
            dropped     <= 1'b0;
            bit_cnt     <= 4'd0;
            byte_cnt    <= 2'd0;
            shreg       <= 8'h00;
            sda_oe      <= 1'b0;
            start_count <= 0;
            wr_count    <= 0;
            rec_addr    <= 8'h00;
            rec_reg     <= 8'h00;
            rec_value   <= 8'h00;
            rec_nacked  <= 1'b0;
        end else begin
            scl_d <= scl;
            sda_d <= sda;
            if (scl_d && scl && sda_d && !sda) begin
                // start: sda falls with scl high
                start_count <= start_count + 1;
                busy        <= 1'b1;
                ack_slot    <= 1'b0;
                selected    <= 1'b0;
                dropped     <= 1'b0;
                bit_cnt     <= 4'd0;
                byte_cnt    <= 2'd0;
                sda_oe      <= 1'b0;
            end else if (scl_d && scl && !sda_d && sda) begin
                // stop: a full address, register and value sequence counts as a write
                busy   <= 1'b0;
                sda_oe <= 1'b0;
                if (selected && byte_cnt == 2'd3) begin
                    wr_count   <= wr_count + 1;
                    rec_addr   <= bytes[0];
                    rec_reg    <= bytes[1];
                    rec_value  <= bytes[2];
                    rec_nacked <= dropped;
                end
            end else if (busy && !scl_d && scl) begin
                // data is sampled on the rising scl edge
                if (!ack_slot) begin
                    shreg   <= {shreg[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (busy && scl_d && !scl) begin
                if (ack_slot) begin
                    // acknowledge clock is over so let go of sda
                    ack_slot <= 1'b0;
                    sda_oe   <= 1'b0;
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt  <= 4'd0;
                    ack_slot <= 1'b1;
                    if (byte_cnt != 2'd3) begin
                        bytes[byte_cnt] <= shreg;
                        byte_cnt        <= byte_cnt + 2'd1;
                    end
                    if (byte_cnt == 2'd0) begin
                        // only our address with the write bit is answered
                        selected <= (shreg == {TARGET_ADDR, 1'b0});
                        sda_oe   <= (shreg == {TARGET_ADDR, 1'b0});
                    end else if (byte_cnt == 2'd2 && wr_count == nack_at) begin
                        dropped <= 1'b1;
                    end else begin
                        sda_oe <= selected;
                    end
                end
            end
        end
    end

endmodule

// File: hdmi_tx_cfg_top.sv
module hdmi_tx_cfg_top #(
    parameter int                          CLK_HZ      = 50_000_000,
    parameter int                          I2C_HZ      = 100_000,
    parameter hdmi_tx_cfg_pkg::chip_addr_t CHIP_ADDR   = hdmi_tx_cfg_pkg::ADV7513_ADDR,
    parameter bit                          PIXEL_REP   = 1'b0,
    parameter bit                          ASPECT_16_9 = 1'b0,
    parameter logic [5:0]                  VIC_MANUAL  = 6'd0
) (
    input  logic clk,
    input  logic reset,
    input  logic hdmi_int,
    input  logic sda_in,
    input  logic scl_in,
    output logic sda_oe,
    output logic scl_oe,
    output logic ready
);
    import hdmi_tx_cfg_pkg::*;

    // table lookup
    logic [IDX_W-1:0] entry_idx;
    reg_entry_t       entry;
    logic             last;

    // sequencer to write engine
    logic             wr_req;
    logic [7:0]       wr_reg;
    logic [7:0]       wr_value;
    logic             wr_ack;
    logic             wr_nack;

    // write engine to byte master
    logic             byte_req;
    logic [7:0]       byte_data;
    logic             byte_start;
    logic             byte_stop;
    logic             byte_ack;
    logic             byte_nack;

    adv7513_init_rom #(
        .PIXEL_REP   (PIXEL_REP),
        .ASPECT_16_9 (ASPECT_16_9),
        .VIC_MANUAL  (VIC_MANUAL)
    ) u_rom (
        .entry_idx (entry_idx),
        .entry     (entry),
        .last      (last)
    );

    adv7513_init_seq u_seq (
        .clk       (clk),
        .reset     (reset),
        .hdmi_int  (hdmi_int),
        .entry_idx (entry_idx),
        .entry     (entry),
        .last      (last),
        .wr_req    (wr_req),
        .wr_reg    (wr_reg),
        .wr_value  (wr_value),
        .wr_ack    (wr_ack),
        .wr_nack   (wr_nack),
        .ready     (ready)
    );

    i2c_reg_write #(
        .CHIP_ADDR (CHIP_ADDR)
    ) u_reg_write (
        .clk        (clk),
        .reset      (reset),
        .wr_req     (wr_req),
        .wr_reg     (wr_reg),
        .wr_value   (wr_value),
        .wr_ack     (wr_ack),
        .wr_nack    (wr_nack),
        .byte_req   (byte_req),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_stop  (byte_stop),
        .byte_ack   (byte_ack),
        .byte_nack  (byte_nack)
    );

    i2c_byte_master #(
        .CLK_HZ (CLK_HZ),
        .I2C_HZ (I2C_HZ)
    ) u_byte_master (
        .clk        (clk),
        .reset      (reset),
        .byte_req   (byte_req),
        .byte_data  (byte_data),
        .byte_start (byte_start),
        .byte_stop  (byte_stop),
        .byte_ack   (byte_ack),
        .byte_nack  (byte_nack),
        .sda_in     (sda_in),
        .scl_in     (scl_in),
        .sda_oe     (sda_oe),
        .scl_oe     (scl_oe)
    );

endmodule

// File: i2c_byte_master.sv
module i2c_byte_master #(
    parameter int CLK_HZ = 50_000_000,
    parameter int I2C_HZ = 100_000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_req,
    input  logic [7:0] byte_data,
    input  logic       byte_start,
    input  logic       byte_stop,
    output logic       byte_ack,
    output logic       byte_nack,
    input  logic       sda_in,
    input  logic       scl_in,
    output logic       sda_oe,
    output logic       scl_oe
);

    // quarter of an scl period in clk cycles
    localparam int QUARTER = (CLK_HZ / (4 * I2C_HZ) > 0) ? CLK_HZ / (4 * I2C_HZ) : 1;
    localparam int DIV_W   = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    typedef enum logic [2:0] {
        s_idle,
        s_start,
        s_bit,
        s_ack,
        s_stop,
        s_done
    } state_t;

    state_t           state;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [1:0]       phase;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic             do_stop;
    // scl parked low after a nack until the stop request arrives
    logic             held;

    assign tick = (div_cnt == DIV_W'(QUARTER - 1));

    // divider only runs while something is on the wire
    always_ff @(posedge clk) begin
        if (!reset) begin
            div_cnt <= '0;
        end else if (state == s_idle || state == s_done || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // msb goes first
    always_ff @(posedge clk) begin
        if (state == s_idle && byte_req) begin
            shift <= byte_data;
        end else if (state == s_bit && tick && phase == 2'd3) begin
            shift <= {shift[6:0], 1'b0};
        end
    end

    // each bit is four quarters
    // sda moves in q0 with scl low, scl rises in q1 and falls in q3
    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= s_idle;
            phase     <= 2'd0;
            bit_cnt   <= 3'd0;
            do_stop   <= 1'b0;
            held      <= 1'b0;
            byte_ack  <= 1'b0;
            byte_nack <= 1'b0;
            sda_oe    <= 1'b0;
            scl_oe    <= 1'b0;
        end else begin
            if (tick) begin
                phase <= phase + 1'b1;
            end
            case (state)
                s_idle: begin
                    if (byte_req) begin
                        phase     <= 2'd0;
                        bit_cnt   <= 3'd7;
                        do_stop   <= byte_stop;
                        byte_nack <= 1'b0;
                        if (held && byte_stop) begin
                            held  <= 1'b0;
                            state <= s_stop;
                        end else if (byte_start) begin
                            state <= s_start;
                        end else begin
                            state <= s_bit;
                        end
                    end
                end
                s_start: begin
                    if (tick) begin
                        case (phase)
                            // sda falls while scl is high
                            2'd1: sda_oe <= 1'b1;
                            2'd3: begin
                                scl_oe <= 1'b1;
                                state  <= s_bit;
                            end
                            default: ;
                        endcase
                    end
                end
                s_bit: begin
                    if (tick) begin
                        case (phase)
                            2'd0: sda_oe <= !shift[7];
                            2'd1: scl_oe <= 1'b0;
                            2'd3: begin
                                scl_oe <= 1'b1;
                                if (bit_cnt == 3'd0) begin
                                    state <= s_ack;
                                end else begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                s_ack: begin
                    if (tick) begin
                        case (phase)
                            // let the target pull sda
                            2'd0: sda_oe <= 1'b0;
                            2'd1: scl_oe <= 1'b0;
                            // high sda in the middle of scl high is a nack
                            2'd2: byte_nack <= sda_in;
                            2'd3: begin
                                scl_oe <= 1'b1;
                                if (do_stop) begin
                                    state <= s_stop;
                                end else begin
                                    held     <= byte_nack;
                                    byte_ack <= 1'b1;
                                    state    <= s_done;
                                end
                            end
                        endcase
                    end
                end
                s_stop: begin
                    if (tick) begin
                        case (phase)
                            2'd0: sda_oe <= 1'b1;
                            2'd1: scl_oe <= 1'b0;
                            // sda rises while scl is high
                            2'd2: sda_oe <= 1'b0;
                            2'd3: begin
                                byte_ack <= 1'b1;
                                state    <= s_done;
                            end
                        endcase
                    end
                end
                s_done: begin
                    if (!byte_req) begin
                        byte_ack <= 1'b0;
                        state    <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // with scl high on the bus only start and stop may move sda
    assert property (@(posedge clk) disable iff (!reset)
        $changed(sda_oe) && $past(scl_in) |-> $past(state) inside {s_start, s_stop});

endmodule

// File: i2c_reg_write.sv
module i2c_reg_write #(
    parameter hdmi_tx_cfg_pkg::chip_addr_t CHIP_ADDR = hdmi_tx_cfg_pkg::ADV7513_ADDR
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_req,
    input  logic [7:0] wr_reg,
    input  logic [7:0] wr_value,
    output logic       wr_ack,
    output logic       wr_nack,
    output logic       byte_req,
    output logic [7:0] byte_data,
    output logic       byte_start,
    output logic       byte_stop,
    input  logic       byte_ack,
    input  logic       byte_nack
);

    typedef enum logic [1:0] {
        s_idle,
        s_send,
        s_release,
        s_ack
    } state_t;

    state_t state;

    // 0 address, 1 register, 2 value with stop, 3 bare stop
    logic [1:0] step;

    // set once any byte of this write went unacknowledged
    logic nack_seen;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= s_idle;
            step       <= 2'd0;
            nack_seen  <= 1'b0;
            wr_ack     <= 1'b0;
            wr_nack    <= 1'b0;
            byte_req   <= 1'b0;
            byte_data  <= 8'h00;
            byte_start <= 1'b0;
            byte_stop  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    // address byte with the write bit behind a start
                    if (wr_req) begin
                        step       <= 2'd0;
                        nack_seen  <= 1'b0;
                        byte_req   <= 1'b1;
                        byte_data  <= {CHIP_ADDR, 1'b0};
                        byte_start <= 1'b1;
                        byte_stop  <= 1'b0;
                        state      <= s_send;
                    end
                end
                s_send: begin
                    if (byte_ack) begin
                        byte_req <= 1'b0;
                        // the bare stop has no acknowledge to judge
                        if (byte_nack && step != 2'd3) begin
                            nack_seen <= 1'b1;
                        end
                        state <= s_release;
                    end
                end
                s_release: begin
                    if (!byte_ack) begin
                        if (step[1]) begin
                            // value byte or bare stop closed the transaction
                            wr_ack  <= 1'b1;
                            wr_nack <= nack_seen;
                            state   <= s_ack;
                        end else if (nack_seen) begin
                            // target dropped out so only release the bus
                            step       <= 2'd3;
                            byte_req   <= 1'b1;
                            byte_data  <= 8'hff;
                            byte_start <= 1'b0;
                            byte_stop  <= 1'b1;
                            state      <= s_send;
                        end else begin
                            step       <= step + 1'b1;
                            byte_req   <= 1'b1;
                            byte_data  <= step[0] ? wr_value : wr_reg;
                            byte_start <= 1'b0;
                            byte_stop  <= step[0];
                            state      <= s_send;
                        end
                    end
                end
                s_ack: begin
                    if (!wr_req) begin
                        wr_ack <= 1'b0;
                        state  <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // no byte goes out while the finished write is being reported
    assert property (@(posedge clk) disable iff (!reset)
        !(byte_req && wr_ack));

endmodule

// File: adv7513_init_seq.sv
module adv7513_init_seq (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              hdmi_int,
    output logic [hdmi_tx_cfg_pkg::IDX_W-1:0] entry_idx,
    input  hdmi_tx_cfg_pkg::reg_entry_t       entry,
    input  logic                              last,
    output logic                              wr_req,
    output logic [7:0]                        wr_reg,
    output logic [7:0]                        wr_value,
    input  logic                              wr_ack,
    input  logic                              wr_nack,
    output logic                              ready
);

    typedef enum logic [1:0] {
        s_issue,
        s_wait_ack,
        s_wait_ack_low,
        s_idle
    } state_t;

    state_t state;

    // result of the handshake that just finished
    logic wr_ok;

    // entry is only looked at while no write is outstanding
    always_ff @(posedge clk) begin
        if (state == s_issue) begin
            wr_reg   <= entry.addr;
            wr_value <= entry.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= s_issue;
            entry_idx <= '0;
            wr_req    <= 1'b0;
            wr_ok     <= 1'b0;
            ready     <= 1'b0;
        end else begin
            case (state)
                s_issue: begin
                    // payload is latched on this same edge
                    wr_req <= 1'b1;
                    state  <= s_wait_ack;
                end
                s_wait_ack: begin
                    if (wr_ack) begin
                        wr_req <= 1'b0;
                        wr_ok  <= !wr_nack;
                        state  <= s_wait_ack_low;
                    end
                end
                s_wait_ack_low: begin
                    // index still points at the entry just written
                    if (!wr_ack) begin
                        if (!wr_ok) begin
                            // no ack from the target so send the same entry again
                            state <= s_issue;
                        end else if (last) begin
                            entry_idx <= '0;
                            ready     <= 1'b1;
                            state     <= s_idle;
                        end else begin
                            entry_idx <= entry_idx + 1'b1;
                            state     <= s_issue;
                        end
                    end
                end
                s_idle: begin
                    // interrupt pending so replay the table from the top
                    if (!hdmi_int) begin
                        ready <= 1'b0;
                        state <= s_issue;
                    end
                end
                default: state <= s_issue;
            endcase
        end
    end

    // a raised request is held until the write engine answers
    assert property (@(posedge clk) disable iff (!reset)
        $fell(wr_req) |-> $past(wr_ack));

endmodule

// File: adv7513_init_rom.sv
module adv7513_init_rom #(
    parameter bit         PIXEL_REP   = 1'b0,
    parameter bit         ASPECT_16_9 = 1'b0,
    parameter logic [5:0] VIC_MANUAL  = 6'd0
) (
    input  logic [hdmi_tx_cfg_pkg::IDX_W-1:0] entry_idx,
    output hdmi_tx_cfg_pkg::reg_entry_t       entry,
    output logic                              last
);
    import hdmi_tx_cfg_pkg::*;

    // final index moves out by two when pixel repetition is enabled
    localparam logic [IDX_W-1:0] LAST_IDX =
        IDX_W'(PIXEL_REP ? INIT_LEN_PR - 1 : INIT_LEN_BASE - 1);

    // input aspect ratio bit in register 17
    localparam logic [7:0] REG17_VAL = ASPECT_16_9 ? 8'h02 : 8'h00;

    assign last = (entry_idx == LAST_IDX);

    always_comb begin
        entry = '0;
        case (entry_idx)
            // power up all circuits with sync adjust off
            5'd0:  entry = {8'h41, 8'h10};
            // fixed values the datasheet asks for
            5'd1:  entry = {8'h98, 8'h03};
            5'd2:  entry = {8'h9a, 8'he0};
            5'd3:  entry = {8'h9c, 8'h30};
            5'd4:  entry = {8'h9d, 8'h01};
            5'd5:  entry = {8'ha2, 8'ha4};
            5'd6:  entry = {8'ha3, 8'ha4};
            5'd7:  entry = {8'he0, 8'hd0};
            5'd8:  entry = {8'hf9, 8'h00};
            // 44.1 kHz i2s and 24 bit rgb 444 with separate syncs
            5'd9:  entry = {8'h15, 8'h00};
            // 444 output at 8 bits per colour
            5'd10: entry = {8'h16, 8'h30};
            // sync polarity passes through
            5'd11: entry = {8'h17, REG17_VAL};
            // colour space converter off
            5'd12: entry = {8'h18, 8'h46};
            // hdmi mode without hdcp
            5'd13: entry = {8'haf, 8'h06};
            // no clock delay
            5'd14: entry = {8'hba, 8'h60};
            // automatic cts from i2s at 128 fs
            5'd15: entry = {8'h0a, 8'h00};
            // audio n value 0x1880 for 44.1 kHz
            5'd16: entry = {8'h01, 8'h00};
            5'd17: entry = {8'h02, 8'h18};
            5'd18: entry = {8'h03, 8'h80};
            // spdif off and mclk generated inside
            5'd19: entry = {8'h0b, 8'h0e};
            // i2s0 only in right justified mode
            5'd20: entry = {8'h0c, 8'h05};
            // 16 bit samples
            5'd21: entry = {8'h0d, 8'h10};
            // enable hpd and monitor sense interrupts
            5'd22: entry = {8'h94, 8'hc0};
            // writing ones here clears the pending interrupts
            5'd23: entry = {8'h96, 8'hc0};
            // manual pixel repetition x2
            5'd24: entry = PIXEL_REP ? {8'h3b, 8'hc8} : '0;
            // vic sent in the avi infoframe
            5'd25: entry = PIXEL_REP ? {8'h3c, 2'b00, VIC_MANUAL} : '0;
            default: entry = '0;
        endcase
    end

endmodule

// File: hdmi_tx_cfg_pkg.sv
package hdmi_tx_cfg_pkg;

    // 7-bit i2c target address without the r/w bit
    typedef logic [6:0] chip_addr_t;

    // one table entry
    // register address sits in the upper byte
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] value;
    } reg_entry_t;

    // table length without the pixel repetition pair
    localparam int INIT_LEN_BASE = 24;

    // table length with 3B and 3C appended
    localparam int INIT_LEN_PR = 26;

    // wide enough for the longer table
    localparam int IDX_W = 5;

    // adv7513 main map with the pd pin strapped low
    localparam chip_addr_t ADV7513_ADDR = 7'h39;

endpackage
